/* dcache_tag_lookup.f */
+incdir+source
source/dcache_tag_pkg.sv
source/tagv_ram.sv
source/tag_valid_memory.sv
source/plru_state.sv
source/dcache_tag_lookup.sv
test/tb_clock_gen.sv
test/dcache_tag_asserts.sv
test/dcache_tag_lookup_tb.sv

/* Bender.yml */
package:
  name: dcache_tag_lookup

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/dcache_tag_pkg.sv
      - source/tagv_ram.sv
      - source/tag_valid_memory.sv
      - source/plru_state.sv
      - source/dcache_tag_lookup.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_clock_gen.sv
      - test/dcache_tag_asserts.sv
      - test/dcache_tag_lookup_tb.sv

/* test/dcache_tag_lookup_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_tag_cfg.svh"

module dcache_tag_lookup_tb;
    import dcache_tag_pkg::*;

    localparam int ADDR_W  = `DCACHE_TAG_W + `DCACHE_INDEX_W + `DCACHE_OFFSET_W;
    localparam int TIMEOUT = 20;    // cycles allowed for any single wait.

    typedef enum logic [1:0] {
        OP_LOOKUP,
        OP_FILL,
        OP_RESET
    } op_e;

    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        way_t              fill_way;
        logic              exp_hit;
        way_t              exp_hit_way;
        way_t              exp_victim_way;
        tag_t              exp_victim_tag;
        logic              exp_victim_vld;
    } row_t;

    logic              clk;
    logic              por_reset;
    logic              soft_reset;
    logic              reset;
    logic              lookup_valid;
    logic [ADDR_W-1:0] lookup_addr;
    logic              fill_valid;
    logic [ADDR_W-1:0] fill_addr;
    way_t              fill_way;
    logic              result_valid;
    logic              hit;
    way_t              hit_way;
    way_t              victim_way;
    tag_t              victim_tag;
    logic              victim_vld;

    row_t rows[$];
    int   row_errors;
    int   failed_rows;
    int   total_errors;

    assign reset = por_reset | soft_reset;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) u_clock_gen (
        .clk   (clk),
        .reset (por_reset)
    );

    dcache_tag_lookup dut_i (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_way     (fill_way),
        .result_valid (result_valid),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_vld   (victim_vld)
    );

    task automatic add_row(input op_e op, input logic [ADDR_W-1:0] addr, input way_t fway,
                           input logic e_hit, input way_t e_hit_way, input way_t e_vway,
                           input tag_t e_vtag, input logic e_vvld);
        row_t r;
        r.op             = op;
        r.addr           = addr;
        r.fill_way       = fway;
        r.exp_hit        = e_hit;
        r.exp_hit_way    = e_hit_way;
        r.exp_victim_way = e_vway;
        r.exp_victim_tag = e_vtag;
        r.exp_victim_vld = e_vvld;
        rows.push_back(r);
    endtask

    // set 5 is at 0x140, set 42 at 0xa80. tags sit in bits 31:12.
    task automatic build_table();
        add_row(OP_LOOKUP, 32'h0000_1140, 4'h0, 1'b0, 4'h0, WAY0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'habcd_e7c0, 4'h0, 1'b0, 4'h0, WAY0, 20'h0, 1'b0);
        add_row(OP_FILL,   32'h0001_0140, WAY0, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0001_0140, 4'h0, 1'b1, WAY0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY1, 20'h0, 1'b0);
        add_row(OP_FILL,   32'h0001_1140, WAY1, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY2, 20'h0, 1'b0);
        add_row(OP_FILL,   32'h0001_2140, WAY2, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY3, 20'h0, 1'b0);
        add_row(OP_FILL,   32'h0001_3140, WAY3, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        // set 5 full, tree entry is 000.
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY0, 20'h10, 1'b1);
        add_row(OP_LOOKUP, 32'h0001_0140, 4'h0, 1'b1, WAY0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY2, 20'h12, 1'b1);
        add_row(OP_LOOKUP, 32'h0001_2140, 4'h0, 1'b1, WAY2, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY1, 20'h11, 1'b1);
        add_row(OP_LOOKUP, 32'h0001_1140, 4'h0, 1'b1, WAY1, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY3, 20'h13, 1'b1);
        add_row(OP_LOOKUP, 32'h0001_3140, 4'h0, 1'b1, WAY3, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY0, 20'h10, 1'b1);
        // set 42 next to set 5.
        add_row(OP_LOOKUP, 32'h0001_0a80, 4'h0, 1'b0, 4'h0, WAY0, 20'h0, 1'b0);
        add_row(OP_FILL,   32'h0005_5a80, WAY1, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0005_5a80, 4'h0, 1'b1, WAY1, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0005_6a80, 4'h0, 1'b0, 4'h0, WAY0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY0, 20'h10, 1'b1);
        add_row(OP_LOOKUP, 32'h0001_0140, 4'h0, 1'b1, WAY0, 4'h0, 20'h0, 1'b0);
        // this fill lands with the hit above, so set 5 keeps 000.
        add_row(OP_FILL,   32'h0007_7a80, WAY0, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY0, 20'h10, 1'b1);
        add_row(OP_LOOKUP, 32'h0007_7a80, 4'h0, 1'b1, WAY0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0005_6a80, 4'h0, 1'b0, 4'h0, WAY2, 20'h0, 1'b0);
        add_row(OP_RESET,  32'h0000_0000, 4'h0, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0001_0140, 4'h0, 1'b0, 4'h0, WAY0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0005_5a80, 4'h0, 1'b0, 4'h0, WAY0, 20'h0, 1'b0);
        add_row(OP_FILL,   32'h0001_0140, WAY3, 1'b0, 4'h0, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0001_0140, 4'h0, 1'b1, WAY3, 4'h0, 20'h0, 1'b0);
        add_row(OP_LOOKUP, 32'h0002_0140, 4'h0, 1'b0, 4'h0, WAY0, 20'h0, 1'b0);
    endtask

    task automatic check_value(input int idx, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED row %0d: %s got %h expected %h", idx, name, got, exp);
            row_errors++;
        end
    endtask

    task automatic wait_reset_release(output logic released);
        int waited;
        waited = 0;
        while (reset !== 1'b0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        released = (reset === 1'b0);
    endtask

    task automatic run_lookup(input int idx, input row_t r);
        int waited;
        lookup_valid = 1'b1;
        lookup_addr  = r.addr;
        @(negedge clk);
        lookup_valid = 1'b0;
        waited = 0;
        while (result_valid !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (result_valid !== 1'b1) begin
            $display("row %0d: the lookup result never came back from the DUT", idx);
            row_errors++;
        end else begin
            check_value(idx, "hit", hit, r.exp_hit);
            check_value(idx, "hit_way", hit_way, r.exp_hit_way);
            if (!r.exp_hit) begin
                check_value(idx, "victim_way", victim_way, r.exp_victim_way);
                check_value(idx, "victim_vld", victim_vld, r.exp_victim_vld);
                if (r.exp_victim_vld) begin
                    check_value(idx, "victim_tag", victim_tag, r.exp_victim_tag);
                end
            end
        end
    endtask

    task automatic run_fill(input row_t r);
        fill_valid = 1'b1;
        fill_addr  = r.addr;
        fill_way   = r.fill_way;
        @(negedge clk);
        fill_valid = 1'b0;
        fill_way   = '0;
    endtask

    task automatic run_reset(input int idx);
        logic released;
        soft_reset = 1'b1;
        repeat (2) @(negedge clk);
        soft_reset = 1'b0;
        wait_reset_release(released);
        if (!released) begin
            $display("row %0d: reset stayed high after it was released", idx);
            row_errors++;
        end
    endtask

    initial begin
        logic released;
        lookup_valid = 1'b0;
        lookup_addr  = '0;
        fill_valid   = 1'b0;
        fill_addr    = '0;
        fill_way     = '0;
        soft_reset   = 1'b0;
        failed_rows  = 0;
        total_errors = 0;
        build_table();

        @(negedge clk);
        wait_reset_release(released);
        if (!released) begin
            $display("power-on reset never went low");
            total_errors++;
        end

        for (int i = 0; i < rows.size(); i++) begin
            row_errors = 0;
            case (rows[i].op)
                OP_LOOKUP: run_lookup(i, rows[i]);
                OP_FILL:   run_fill(rows[i]);
                default:   run_reset(i);
            endcase
            $display("row %0d %s addr %h: %s", i, rows[i].op.name(), rows[i].addr,
                     (row_errors == 0) ? "ok" : "bad");
            if (row_errors != 0) begin
                failed_rows++;
            end
            total_errors += row_errors;
        end

        $display("%0d rows run, %0d rows failed, %0d errors in total",
                 rows.size(), failed_rows, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/dcache_tag_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 lookup_valid,
    input logic                 result_valid,
    input logic                 hit,
    input dcache_tag_pkg::way_t hit_way
);
    import dcache_tag_pkg::*;

    a_result_follows: assert property (@(posedge clk) disable iff (reset)
        lookup_valid |=> result_valid)
        else $error("result_valid missing one cycle after lookup_valid");

    a_no_spurious_result: assert property (@(posedge clk) disable iff (reset)
        !lookup_valid |=> !result_valid)
        else $error("result_valid raised without a lookup in the previous cycle");

    a_hit_way_onehot0: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $onehot0(hit_way))
        else $error("hit_way has more than one bit set");

    a_hit_matches_way: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (hit == (hit_way != '0)))
        else $error("hit disagrees with hit_way");

    a_quiet_in_reset: assert property (@(posedge clk)
        reset |=> !result_valid)
        else $error("result_valid high after a reset cycle");

endmodule

bind dcache_tag_lookup dcache_tag_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .lookup_valid (lookup_valid),
    .result_valid (result_valid),
    .hit          (hit),
    .hit_way      (hit_way)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, like every other testbench input.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* source/dcache_tag_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_tag_cfg.svh"

module dcache_tag_lookup (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 lookup_valid,
    input  logic [`DCACHE_TAG_W+`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1:0] lookup_addr,
    input  logic                 fill_valid,
    input  logic [`DCACHE_TAG_W+`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1:0] fill_addr,
    input  dcache_tag_pkg::way_t fill_way,
    output logic                 result_valid,
    output logic                 hit,
    output dcache_tag_pkg::way_t hit_way,
    output dcache_tag_pkg::way_t victim_way,
    output dcache_tag_pkg::tag_t victim_tag,
    output logic                 victim_vld
);
    import dcache_tag_pkg::*;

    localparam int TAG_LSB = `DCACHE_OFFSET_W + `DCACHE_INDEX_W;

    index_t lookup_index;
    tag_t   lookup_tag;
    index_t fill_index;
    tag_t   fill_tag;

    logic   lookup_valid_q;
    index_t lookup_index_q;
    tag_t   lookup_tag_q;

    way_t   vld_vec;
    way_t   plru_victim;
    way_t   fill_we;

    logic   touch_en;
    index_t touch_index;
    way_t   touch_way;

    assign lookup_index = lookup_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign lookup_tag   = lookup_addr[TAG_LSB +: `DCACHE_TAG_W];
    assign fill_index   = fill_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign fill_tag     = fill_addr[TAG_LSB +: `DCACHE_TAG_W];

    assign fill_we = fill_valid ? fill_way : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_valid;
        end
    end

    // tag and index line up with the ram read in the next cycle.
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            lookup_index_q <= lookup_index;
            lookup_tag_q   <= lookup_tag;
        end
    end

    tag_valid_memory u_tag_valid_memory (
        .clk         (clk),
        .reset       (reset),
        .rd_index    (lookup_index),    // raw index, ram adds the cycle.
        .lookup_tag  (lookup_tag_q),
        .wr_index    (fill_index),
        .wr_tag      (fill_tag),
        .we          (fill_we),
        .way_sel     (victim_way),
        .hit         (hit_way),
        .vld         (vld_vec),
        .replace_tag (victim_tag),
        .replace_vld (victim_vld)
    );

    plru_state u_plru_state (
        .clk         (clk),
        .reset       (reset),
        .rd_index    (lookup_index_q),
        .victim      (plru_victim),
        .touch_en    (touch_en),
        .touch_index (touch_index),
        .touch_way   (touch_way)
    );

    assign result_valid = lookup_valid_q;
    assign hit          = |hit_way;

    // lowest invalid way first, tree choice once the set is full.
    always_comb begin
        victim_way = plru_victim;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!vld_vec[w]) begin
                victim_way = way_t'(1 << w);
            end
        end
    end

    // one touch per cycle, a fill beats a hit.
    always_comb begin
        touch_en    = 1'b0;
        touch_index = fill_index;
        touch_way   = fill_way;
        if (fill_valid) begin
            touch_en = 1'b1;
        end else if (lookup_valid_q && hit) begin
            touch_en    = 1'b1;
            touch_index = lookup_index_q;
            touch_way   = hit_way;
        end
    end

endmodule

`default_nettype wire

/* source/plru_state.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_tag_cfg.svh"

module plru_state (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_tag_pkg::index_t rd_index,
    output dcache_tag_pkg::way_t   victim,
    input  logic                   touch_en,
    input  dcache_tag_pkg::index_t touch_index,
    input  dcache_tag_pkg::way_t   touch_way
);
    import dcache_tag_pkg::*;

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    plru_t plru_mem [SETS];
    plru_t rd_entry;
    plru_t touch_entry;
    plru_t touch_next;

    assign rd_entry    = plru_mem[rd_index];
    assign touch_entry = plru_mem[touch_index];

    // walk the tree from the root.
    always_comb begin
        if (!rd_entry[PLRU_ROOT]) begin
            victim = rd_entry[PLRU_LEFT] ? WAY1 : WAY0;
        end else begin
            victim = rd_entry[PLRU_RIGHT] ? WAY3 : WAY2;
        end
    end

    // point the root and the pair bit away from the touched way.
    always_comb begin
        touch_next = touch_entry;
        case (touch_way)
            WAY0: begin
                touch_next[PLRU_ROOT] = 1'b1;
                touch_next[PLRU_LEFT] = 1'b1;
            end
            WAY1: begin
                touch_next[PLRU_ROOT] = 1'b1;
                touch_next[PLRU_LEFT] = 1'b0;
            end
            WAY2: begin
                touch_next[PLRU_ROOT]  = 1'b0;
                touch_next[PLRU_RIGHT] = 1'b1;
            end
            WAY3: begin
                touch_next[PLRU_ROOT]  = 1'b0;
                touch_next[PLRU_RIGHT] = 1'b0;
            end
            default: begin
                touch_next = touch_entry;    // no single way, keep the entry.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SETS; i++) begin
                plru_mem[i] <= '0;
            end
        end else if (touch_en) begin
            plru_mem[touch_index] <= touch_next;
        end
    end

endmodule

`default_nettype wire

/* source/tag_valid_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_tag_cfg.svh"

module tag_valid_memory (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_tag_pkg::index_t rd_index,
    input  dcache_tag_pkg::tag_t   lookup_tag,
    input  dcache_tag_pkg::index_t wr_index,
    input  dcache_tag_pkg::tag_t   wr_tag,
    input  dcache_tag_pkg::way_t   we,
    input  dcache_tag_pkg::way_t   way_sel,
    output dcache_tag_pkg::way_t   hit,
    output dcache_tag_pkg::way_t   vld,
    output dcache_tag_pkg::tag_t   replace_tag,
    output logic                   replace_vld
);
    import dcache_tag_pkg::*;

    tag_t way_tag [`DCACHE_WAYS];
    way_t way_vld;

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        tagv_ram u_tagv (
            .clk      (clk),
            .reset    (reset),
            .wr_en    (we[w]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .rd_index (rd_index),
            .rd_tag   (way_tag[w]),
            .rd_vld   (way_vld[w])
        );

        // lookup_tag is already aligned with the ram output.
        assign hit[w] = way_vld[w] && (way_tag[w] == lookup_tag);
    end

    assign vld = way_vld;

    // victim readout, anything but a single way gives zero.
    always_comb begin
        case (way_sel)
            WAY0: begin
                replace_tag = way_tag[0];
                replace_vld = way_vld[0];
            end
            WAY1: begin
                replace_tag = way_tag[1];
                replace_vld = way_vld[1];
            end
            WAY2: begin
                replace_tag = way_tag[2];
                replace_vld = way_vld[2];
            end
            WAY3: begin
                replace_tag = way_tag[3];
                replace_vld = way_vld[3];
            end
            default: begin
                replace_tag = '0;
                replace_vld = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/tagv_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_tag_cfg.svh"

module tagv_ram (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  dcache_tag_pkg::index_t wr_index,
    input  dcache_tag_pkg::tag_t   wr_tag,
    input  dcache_tag_pkg::index_t rd_index,
    output dcache_tag_pkg::tag_t   rd_tag,
    output logic                   rd_vld
);
    import dcache_tag_pkg::*;

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    tag_t            tag_mem [SETS];
    logic [SETS-1:0] vld_mem;

    // block ram style port, old data comes out on a same-cycle write.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
        rd_tag <= tag_mem[rd_index];
    end

    // valid bits live in flops so reset can clear all sets at once.
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_mem <= '0;
            rd_vld  <= 1'b0;
        end else begin
            if (wr_en) begin
                vld_mem[wr_index] <= 1'b1;    // a fill always leaves the line valid.
            end
            rd_vld <= vld_mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* source/dcache_tag_pkg.sv */
`default_nettype none

`include "dcache_tag_cfg.svh"

package dcache_tag_pkg;

    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_WAYS-1:0]    way_t;   // one-hot way vector.

    // tree bits: root picks the pair, then the pair bit picks the way.
    typedef logic [2:0] plru_t;

    localparam int PLRU_ROOT  = 0;
    localparam int PLRU_LEFT  = 1;
    localparam int PLRU_RIGHT = 2;

    localparam way_t WAY0 = 4'b0001;
    localparam way_t WAY1 = 4'b0010;
    localparam way_t WAY2 = 4'b0100;
    localparam way_t WAY3 = 4'b1000;

endpackage

`default_nettype wire

/* source/dcache_tag_cfg.svh */
`ifndef DCACHE_TAG_CFG_SVH
`define DCACHE_TAG_CFG_SVH

// address split for 64 sets of 64-byte lines.
`define DCACHE_TAG_W    20
`define DCACHE_INDEX_W  6
`define DCACHE_OFFSET_W 6

// associativity.
`define DCACHE_WAYS     4

`endif
